// ==== logic/mmu_arch_pkg.sv ====
package mmu_arch_pkg;

    ////////////////////
    // Privilege and access types
    ////////////////////

    typedef enum logic [1:0] {
        plv_kernel = 2'd0,
        plv_user   = 2'd3
    } plv_t;

    typedef enum logic [1:0] {
        mat_suc = 2'd0, // Strongly ordered, uncached.
        mat_cc  = 2'd1  // Coherent, cached.
    } mat_t;

    // Current mode register as the translator sees it.
    typedef struct packed {
        mat_t datm;
        mat_t datf;
        logic pg;
        logic da;
        logic ie;
        plv_t plv;
    } crmd_t;

    // Field layout follows the DMW CSR bit positions.
    typedef struct packed {
        logic [2:0]  vseg;      // Bits 31 to 29.
        logic        rsvd_28;
        logic [2:0]  pseg;      // Bits 27 to 25.
        logic [18:0] rsvd_24_6;
        mat_t        mat;
        logic        plv3;
        logic [1:0]  rsvd_2_1;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        crmd_t      crmd;
        logic [9:0] asid;
        dmw_t [1:0] dmw;
    } csr_t;

    ////////////////////
    // Exceptions
    ////////////////////

    typedef enum logic [3:0] {
        ecode_none = 4'd0,
        ecode_adef = 4'd1, // Fetch address error.
        ecode_adem = 4'd2, // Data address error.
        ecode_ale  = 4'd3, // Misaligned data access.
        ecode_tlbr = 4'd4, // TLB refill.
        ecode_pil  = 4'd5,
        ecode_pis  = 4'd6,
        ecode_pif  = 4'd7,
        ecode_pme  = 4'd8, // Store to a clean page.
        ecode_ppi  = 4'd9  // Privilege violation.
    } ecode_t;

    typedef struct packed {
        logic        valid;
        ecode_t      ecode;
        logic [31:0] badv;
    } excp_t;

endpackage

// ==== logic/mmu_tlb_pkg.sv ====
package mmu_tlb_pkg;

    ////////////////////
    // Access description
    ////////////////////

    typedef enum logic [1:0] {
        lookup_fetch = 2'd0,
        lookup_load  = 2'd1,
        lookup_store = 2'd2
    } lookup_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    ////////////////////
    // TLB entry
    ////////////////////

    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    typedef struct packed {
        logic [19:0]        ppn;
        logic               v;
        logic               d;  // Dirty, cleared pages fault on store.
        mmu_arch_pkg::plv_t plv;
        mmu_arch_pkg::mat_t mat;
    } tlb_page_t;

    // Each entry maps an even and odd page pair, so vppn starts one bit above ps.
    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        tlb_page_t   even;
        tlb_page_t   odd;
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] va;
        lookup_t     lookup;
        size_t       size;
    } mmu_req_t;

    typedef struct packed {
        logic [31:0]         pa;
        mmu_arch_pkg::mat_t  mat;
        mmu_arch_pkg::excp_t excp;
    } mmu_resp_t;

endpackage

// ==== logic/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Accept when empty or when the held item leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    stall_keeps_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else $error("pipe_stage dropped a stalled item.");

    stall_keeps_data: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("pipe_stage changed data under stall.");

endmodule

// ==== logic/tlb_array.sv ====
`timescale 1ns/1ps

module tlb_array #(
    parameter int tlb_entries = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             we,
    input  logic [$clog2(tlb_entries)-1:0]   index,
    input  mmu_tlb_pkg::tlb_entry_t          wentry,
    output mmu_tlb_pkg::tlb_entry_t          entries [tlb_entries]
);

    ////////////////////
    // Storage
    ////////////////////

    // Only the exist bit is cleared on reset.
    // The rest of an entry is meaningless until software writes it.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (we) begin
            entries[index] <= wentry;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The write index comes from software and may exceed a non power of two depth.
    write_index_in_range: assert property (@(posedge clk) disable iff (reset)
        we |-> int'(index) < tlb_entries)
        else $error("tlb_array write index %0d out of range.", index);

endmodule

// ==== logic/tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int tlb_entries = 16
) (
    input  mmu_tlb_pkg::tlb_entry_t entries [tlb_entries],
    input  logic [9:0]              asid,
    input  mmu_arch_pkg::plv_t      plv,
    input  logic [31:0]             va,
    input  mmu_tlb_pkg::lookup_t    lookup,
    output logic [31:0]             pa,
    output mmu_arch_pkg::mat_t      mat,
    output mmu_arch_pkg::ecode_t    ecode,
    output logic                    is_exc
);

    logic                    found;
    mmu_tlb_pkg::tlb_entry_t hit_entry;
    mmu_tlb_pkg::tlb_page_t  page;
    logic                    huge;

    // A 2 MB pair compares only the upper ten bits of vppn.
    function automatic logic vppn_hit(mmu_tlb_pkg::tlb_entry_t ent, logic [31:0] addr);
        if (ent.ps == mmu_tlb_pkg::ps_2m) begin
            return ent.vppn[18:9] == addr[31:22];
        end
        return ent.vppn == addr[31:13];
    endfunction

    ////////////////////
    // Entry match
    ////////////////////

    // Scanning downward leaves the lowest matching index selected.
    always_comb begin
        found     = 1'b0;
        hit_entry = entries[0];
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (entries[i].e && (entries[i].g || entries[i].asid == asid) &&
                vppn_hit(entries[i], va)) begin
                found     = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    assign huge = (hit_entry.ps == mmu_tlb_pkg::ps_2m);
    assign page = (huge ? va[21] : va[12]) ? hit_entry.odd : hit_entry.even;
    assign pa   = huge ? {page.ppn[19:9], va[20:0]} : {page.ppn, va[11:0]};
    assign mat  = page.mat;

    ////////////////////
    // Page faults
    ////////////////////

    always_comb begin
        ecode = mmu_arch_pkg::ecode_none;
        if (!found) begin
            ecode = mmu_arch_pkg::ecode_tlbr;
        end else if (!page.v) begin
            unique case (lookup)
                mmu_tlb_pkg::lookup_fetch: ecode = mmu_arch_pkg::ecode_pif;
                mmu_tlb_pkg::lookup_store: ecode = mmu_arch_pkg::ecode_pis;
                default:                   ecode = mmu_arch_pkg::ecode_pil;
            endcase
        end else if (plv > page.plv) begin
            ecode = mmu_arch_pkg::ecode_ppi;
        end else if (lookup == mmu_tlb_pkg::lookup_store && !page.d) begin
            ecode = mmu_arch_pkg::ecode_pme;
        end
    end

    assign is_exc = (ecode != mmu_arch_pkg::ecode_none);

endmodule

// ==== logic/addr_trans.sv ====
`timescale 1ns/1ps

module addr_trans #(
    parameter int tlb_entries = 16
) (
    input  logic                    en,
    input  logic [31:0]             va,
    input  mmu_tlb_pkg::lookup_t    lookup,
    input  mmu_tlb_pkg::size_t      size,
    input  mmu_arch_pkg::csr_t      csr,
    input  mmu_tlb_pkg::tlb_entry_t entries [tlb_entries],
    output mmu_arch_pkg::mat_t      mat,
    output logic [31:0]             pa,
    output mmu_arch_pkg::excp_t     excp
);

    logic [31:0]          tlb_pa;
    mmu_arch_pkg::mat_t   tlb_mat;
    mmu_arch_pkg::ecode_t tlb_ecode;
    logic                 tlb_is_exc;
    logic [1:0]           dmw_hit;
    logic                 dmw_found;
    mmu_arch_pkg::dmw_t   dmw_sel;
    logic                 is_direct;
    logic                 is_tlb;
    logic                 is_fetch;
    logic                 align_ok;

    tlb_lookup #(
        .tlb_entries(tlb_entries)
    ) u_tlb_lookup (
        .entries(entries),
        .asid   (csr.asid),
        .plv    (csr.crmd.plv),
        .va     (va),
        .lookup (lookup),
        .pa     (tlb_pa),
        .mat    (tlb_mat),
        .ecode  (tlb_ecode),
        .is_exc (tlb_is_exc)
    );

    ////////////////////
    // Mapping windows
    ////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dmw_hit[i] = (csr.dmw[i].vseg == va[31:29]) &&
                ((csr.crmd.plv == mmu_arch_pkg::plv_kernel && csr.dmw[i].plv0) ||
                 (csr.crmd.plv == mmu_arch_pkg::plv_user && csr.dmw[i].plv3));
        end
    end

    assign dmw_found = |dmw_hit;
    assign dmw_sel   = dmw_hit[1] ? csr.dmw[1] : csr.dmw[0]; // Window 1 has priority.

    assign is_direct = csr.crmd.da;
    assign is_tlb    = !is_direct && !dmw_found;
    assign is_fetch  = (lookup == mmu_tlb_pkg::lookup_fetch);

    always_comb begin
        if (is_direct) begin
            pa  = va;
            mat = is_fetch ? csr.crmd.datf : csr.crmd.datm;
        end else if (dmw_found) begin
            pa  = {dmw_sel.pseg, va[28:0]};
            mat = dmw_sel.mat;
        end else begin
            pa  = tlb_pa;
            mat = tlb_mat;
        end
    end

    ////////////////////
    // Exceptions
    ////////////////////

    always_comb begin
        unique case (size)
            mmu_tlb_pkg::size_half: align_ok = !va[0];
            mmu_tlb_pkg::size_word: align_ok = (va[1:0] == 2'b00);
            default:                align_ok = 1'b1;
        endcase
    end

    // Alignment first, then the user upper half check, then whatever the TLB reports.
    always_comb begin
        excp.valid = 1'b0;
        excp.ecode = mmu_arch_pkg::ecode_none;
        excp.badv  = va;
        if (en) begin
            if (!align_ok) begin
                excp.valid = 1'b1;
                if (is_fetch) begin
                    excp.ecode = mmu_arch_pkg::ecode_adef;
                end else begin
                    excp.ecode = mmu_arch_pkg::ecode_ale;
                end
            end else if (is_tlb && csr.crmd.plv == mmu_arch_pkg::plv_user && va[31]) begin
                excp.valid = 1'b1;
                if (is_fetch) begin
                    excp.ecode = mmu_arch_pkg::ecode_adef;
                end else begin
                    excp.ecode = mmu_arch_pkg::ecode_adem;
                end
            end else if (is_tlb && tlb_is_exc) begin
                excp.valid = 1'b1;
                excp.ecode = tlb_ecode;
            end
        end
    end

endmodule

// ==== logic/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top #(
    parameter int tlb_entries = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  mmu_tlb_pkg::mmu_req_t          req,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output mmu_tlb_pkg::mmu_resp_t         resp,
    input  mmu_arch_pkg::csr_t             csr,
    input  logic                           tlb_we,
    input  logic [$clog2(tlb_entries)-1:0] tlb_index,
    input  mmu_tlb_pkg::tlb_entry_t        tlb_wentry
);

    logic                    s1_valid;
    logic                    s2_ready;
    mmu_tlb_pkg::mmu_req_t   s1_req;
    mmu_tlb_pkg::tlb_entry_t entries [tlb_entries];
    logic [31:0]             trans_pa;
    mmu_arch_pkg::mat_t      trans_mat;
    mmu_arch_pkg::excp_t     trans_excp;
    mmu_tlb_pkg::mmu_resp_t  trans_resp;

    ////////////////////
    // Request stage
    ////////////////////

    pipe_stage #(
        .payload_t(mmu_tlb_pkg::mmu_req_t)
    ) u_req_stage (
        .clk      (clk),
        .reset    (reset),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_data  (req),
        .out_valid(s1_valid),
        .out_ready(s2_ready),
        .out_data (s1_req)
    );

    tlb_array #(
        .tlb_entries(tlb_entries)
    ) u_tlb_array (
        .clk    (clk),
        .reset  (reset),
        .we     (tlb_we),
        .index  (tlb_index),
        .wentry (tlb_wentry),
        .entries(entries)
    );

    // Exceptions are only raised for a live request in stage 1.
    addr_trans #(
        .tlb_entries(tlb_entries)
    ) u_addr_trans (
        .en     (s1_valid),
        .va     (s1_req.va),
        .lookup (s1_req.lookup),
        .size   (s1_req.size),
        .csr    (csr),
        .entries(entries),
        .mat    (trans_mat),
        .pa     (trans_pa),
        .excp   (trans_excp)
    );

    assign trans_resp = '{pa: trans_pa, mat: trans_mat, excp: trans_excp};

    ////////////////////
    // Response stage
    ////////////////////

    pipe_stage #(
        .payload_t(mmu_tlb_pkg::mmu_resp_t)
    ) u_resp_stage (
        .clk      (clk),
        .reset    (reset),
        .in_valid (s1_valid),
        .in_ready (s2_ready),
        .in_data  (trans_resp),
        .out_valid(resp_valid),
        .out_ready(resp_ready),
        .out_data (resp)
    );

endmodule

// ==== verif/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb;

    localparam int tlb_entries = 16;
    localparam int max_cycles  = 4000;

    logic                           clk;
    logic                           reset;
    logic                           req_valid;
    logic                           req_ready;
    mmu_tlb_pkg::mmu_req_t          req;
    logic                           resp_valid;
    logic                           resp_ready;
    mmu_tlb_pkg::mmu_resp_t         resp;
    mmu_arch_pkg::csr_t             csr;
    logic                           tlb_we;
    logic [$clog2(tlb_entries)-1:0] tlb_index;
    mmu_tlb_pkg::tlb_entry_t        tlb_wentry;

    mmu_tlb_pkg::tlb_entry_t        tlb_model [tlb_entries]; // Expected TLB contents.
    mmu_tlb_pkg::mmu_req_t          req_list [$];
    int                             cycles = 0;

    mmu_top #(
        .tlb_entries(tlb_entries)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .resp_valid(resp_valid),
        .resp_ready(resp_ready),
        .resp      (resp),
        .csr       (csr),
        .tlb_we    (tlb_we),
        .tlb_index (tlb_index),
        .tlb_wentry(tlb_wentry)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles.", max_cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic mmu_tlb_pkg::mmu_resp_t expected_resp(mmu_tlb_pkg::mmu_req_t r);
        mmu_tlb_pkg::mmu_resp_t e;
        mmu_arch_pkg::ecode_t   code;
        mmu_tlb_pkg::tlb_page_t pg;
        logic                   fetch;
        logic                   store;
        logic                   misaligned;
        logic [31:0]            mask;
        int                     win;
        int                     hit;
        int                     ps;
        e          = '0;
        code       = mmu_arch_pkg::ecode_none;
        fetch      = (r.lookup == mmu_tlb_pkg::lookup_fetch);
        store      = (r.lookup == mmu_tlb_pkg::lookup_store);
        misaligned = (r.size == mmu_tlb_pkg::size_half && r.va[0]) ||
                     (r.size == mmu_tlb_pkg::size_word && r.va[1:0] != 2'b00);
        win        = -1;
        hit        = -1;
        for (int i = 0; i < 2; i++) begin
            if (csr.dmw[i].vseg == r.va[31:29] &&
                ((csr.crmd.plv == mmu_arch_pkg::plv_kernel && csr.dmw[i].plv0) ||
                 (csr.crmd.plv == mmu_arch_pkg::plv_user && csr.dmw[i].plv3))) begin
                win = i; // The higher window overrides.
            end
        end
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (tlb_model[i].e && (tlb_model[i].g || tlb_model[i].asid == csr.asid) &&
                (r.va >> (tlb_model[i].ps + 1)) ==
                (32'(tlb_model[i].vppn) >> (tlb_model[i].ps - 12))) begin
                hit = i;
            end
        end
        if (csr.crmd.da) begin
            e.pa  = r.va;
            e.mat = fetch ? csr.crmd.datf : csr.crmd.datm;
        end else if (win >= 0) begin
            e.pa  = {csr.dmw[win].pseg, r.va[28:0]};
            e.mat = csr.dmw[win].mat;
        end else begin
            if (hit < 0) begin
                code = mmu_arch_pkg::ecode_tlbr;
            end else begin
                ps    = int'(tlb_model[hit].ps);
                pg    = r.va[ps] ? tlb_model[hit].odd : tlb_model[hit].even;
                mask  = (32'd1 << ps) - 32'd1; // Offset bits below the page size.
                e.pa  = ({pg.ppn, 12'h000} & ~mask) | (r.va & mask);
                e.mat = pg.mat;
                if (!pg.v) begin
                    code = fetch ? mmu_arch_pkg::ecode_pif :
                           (store ? mmu_arch_pkg::ecode_pis : mmu_arch_pkg::ecode_pil);
                end else if (csr.crmd.plv > pg.plv) begin
                    code = mmu_arch_pkg::ecode_ppi;
                end else if (store && !pg.d) begin
                    code = mmu_arch_pkg::ecode_pme;
                end
            end
            if (csr.crmd.plv == mmu_arch_pkg::plv_user && r.va[31]) begin
                code = fetch ? mmu_arch_pkg::ecode_adef : mmu_arch_pkg::ecode_adem;
            end
        end
        if (misaligned) begin
            code = fetch ? mmu_arch_pkg::ecode_adef : mmu_arch_pkg::ecode_ale;
        end
        e.excp.valid = (code != mmu_arch_pkg::ecode_none);
        e.excp.ecode = code;
        e.excp.badv  = r.va;
        return e;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic compare_value(string what, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_resp(mmu_tlb_pkg::mmu_resp_t actual, mmu_tlb_pkg::mmu_resp_t expected);
        string tag;
        tag = $sformatf("va %h", expected.excp.badv);
        compare_value({tag, " exception valid"}, actual.excp.valid, expected.excp.valid);
        compare_value({tag, " exception code"}, actual.excp.ecode, expected.excp.ecode);
        compare_value({tag, " bad address"}, actual.excp.badv, expected.excp.badv);
        if (!expected.excp.valid) begin
            compare_value({tag, " physical address"}, actual.pa, expected.pa);
            compare_value({tag, " access type"}, actual.mat, expected.mat);
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    function automatic mmu_tlb_pkg::tlb_page_t make_page(logic [19:0] ppn, logic v, logic d,
                                                         mmu_arch_pkg::plv_t plv,
                                                         mmu_arch_pkg::mat_t mat);
        mmu_tlb_pkg::tlb_page_t p;
        p = '{ppn: ppn, v: v, d: d, plv: plv, mat: mat};
        return p;
    endfunction

    function automatic mmu_tlb_pkg::tlb_entry_t make_entry(logic [31:0] va, logic [5:0] ps,
                                                           logic g, logic [9:0] asid,
                                                           mmu_tlb_pkg::tlb_page_t even,
                                                           mmu_tlb_pkg::tlb_page_t odd);
        mmu_tlb_pkg::tlb_entry_t t;
        t = '{e: 1'b1, vppn: va[31:13], ps: ps, g: g, asid: asid, even: even, odd: odd};
        return t;
    endfunction

    function automatic logic [31:0] rand_addr(logic [31:0] base, logic [31:0] span);
        return (base + ($urandom % span)) & 32'hffff_fffc;
    endfunction

    function automatic mmu_tlb_pkg::mmu_req_t random_req();
        mmu_tlb_pkg::mmu_req_t r;
        case ($urandom % 4)
            0:       r.va = rand_addr(32'h0040_0000, 32'h0000_2000);
            1:       r.va = rand_addr(32'h1000_0000, 32'h0040_0000);
            2:       r.va = rand_addr(32'h0060_0000, 32'h0000_2000);
            default: r.va = rand_addr(32'h0700_0000, 32'h0010_0000); // Unmapped.
        endcase
        r.lookup = mmu_tlb_pkg::lookup_t'(2'($urandom % 3));
        r.size   = mmu_tlb_pkg::size_word;
        return r;
    endfunction

    task automatic add_req(logic [31:0] va, mmu_tlb_pkg::lookup_t lookup,
                           mmu_tlb_pkg::size_t size);
        req_list.push_back('{va: va, lookup: lookup, size: size});
    endtask

    task automatic write_tlb(int index, mmu_tlb_pkg::tlb_entry_t entry);
        @(negedge clk);
        tlb_we           = 1'b1;
        tlb_index        = index[$clog2(tlb_entries)-1:0];
        tlb_wentry       = entry;
        tlb_model[index] = entry;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    task automatic set_mode(mmu_arch_pkg::plv_t plv, logic da, logic [9:0] asid);
        @(negedge clk);
        csr.crmd.plv  = plv;
        csr.crmd.da   = da;
        csr.crmd.pg   = !da;
        csr.crmd.datf = mmu_arch_pkg::mat_cc;
        csr.crmd.datm = mmu_arch_pkg::mat_suc;
        csr.asid      = asid;
    endtask

    task automatic set_window(int idx, logic [2:0] vseg, logic [2:0] pseg,
                              mmu_arch_pkg::mat_t mat, logic plv0, logic plv3);
        mmu_arch_pkg::dmw_t w;
        w      = '0;
        w.vseg = vseg;
        w.pseg = pseg;
        w.mat  = mat;
        w.plv0 = plv0;
        w.plv3 = plv3;
        @(negedge clk);
        csr.dmw[idx] = w;
    endtask

    // Streams req_list through the DUT and checks each response in order.
    task automatic run_requests(logic stall);
        mmu_tlb_pkg::mmu_resp_t exp_q [$];
        int                     edge_q [$];
        mmu_tlb_pkg::mmu_resp_t exp_resp;
        int                     sent;
        int                     got;
        int                     edge_n;
        logic                   took;
        sent = 0;
        got  = 0;
        took = 1'b0;
        while (got < req_list.size()) begin
            @(negedge clk);
            if (took || !req_valid) begin
                if (sent < req_list.size()) begin
                    req_valid = 1'b1;
                    req       = req_list[sent];
                    exp_q.push_back(expected_resp(req_list[sent]));
                    sent++;
                end else begin
                    req_valid = 1'b0;
                end
            end
            resp_ready = stall ? ($urandom % 3 != 0) : 1'b1;
            #1;
            took = req_valid && req_ready;
            if (took) begin
                edge_q.push_back(cycles); // Cycle in which the request is presented.
            end
            if (resp_valid && resp_ready) begin
                exp_resp = exp_q.pop_front();
                edge_n   = edge_q.pop_front();
                compare_resp(resp, exp_resp);
                if (!stall) begin
                    compare_value("response latency", cycles - edge_n, 2);
                end
                got++;
            end
        end
        @(negedge clk);
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        req_list.delete();
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic direct_mode_test;
        logic [31:0] va;
        set_mode(mmu_arch_pkg::plv_kernel, 1'b1, 10'd0);
        for (int i = 0; i < 8; i++) begin
            va = $urandom & 32'hffff_fffc;
            add_req(va, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
            add_req(va ^ 32'h0000_1000, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        end
        add_req(32'h1234_5671, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_half);
        add_req(32'h1234_5672, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        add_req(32'h1234_5673, mmu_tlb_pkg::lookup_store, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
    endtask

    task automatic window_test;
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'd0);
        set_window(0, 3'b100, 3'b000, mmu_arch_pkg::mat_cc, 1'b1, 1'b0);
        set_window(1, 3'b101, 3'b001, mmu_arch_pkg::mat_suc, 1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            add_req(rand_addr(32'h8000_0000, 32'h2000_0000), mmu_tlb_pkg::lookup_load,
                    mmu_tlb_pkg::size_word);
            add_req(rand_addr(32'hA000_0000, 32'h2000_0000), mmu_tlb_pkg::lookup_fetch,
                    mmu_tlb_pkg::size_word);
        end
        run_requests(1'b0);
        // Window 0 is kernel only, so user accesses there go to the TLB path.
        set_mode(mmu_arch_pkg::plv_user, 1'b0, 10'd0);
        add_req(32'h8000_1000, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h8000_2000, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        add_req(32'hA000_0100, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'd0);
        set_window(0, 3'b101, 3'b010, mmu_arch_pkg::mat_cc, 1'b1, 1'b0);
        add_req(32'hA000_2000, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
    endtask

    task automatic tlb_hit_test;
        set_window(0, 3'b100, 3'b000, mmu_arch_pkg::mat_cc, 1'b0, 1'b0);
        set_window(1, 3'b101, 3'b001, mmu_arch_pkg::mat_suc, 1'b0, 1'b0);
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'h005);
        write_tlb(0, make_entry(32'h0040_0000, mmu_tlb_pkg::ps_4k, 1'b0, 10'h005,
            make_page(20'h12345, 1'b1, 1'b1, mmu_arch_pkg::plv_user, mmu_arch_pkg::mat_cc),
            make_page(20'h54321, 1'b1, 1'b1, mmu_arch_pkg::plv_user, mmu_arch_pkg::mat_suc)));
        write_tlb(1, make_entry(32'h1000_0000, mmu_tlb_pkg::ps_2m, 1'b1, 10'h3ff,
            make_page(20'h00600, 1'b1, 1'b1, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_cc),
            make_page(20'h00a00, 1'b1, 1'b1, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_suc)));
        write_tlb(5, make_entry(32'h0050_0000, mmu_tlb_pkg::ps_4k, 1'b0, 10'h007,
            make_page(20'h0abcd, 1'b1, 1'b1, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_cc),
            make_page(20'h0dcba, 1'b1, 1'b1, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_cc)));
        add_req(32'h0040_0abc, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_byte);
        add_req(32'h0040_1ff0, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h1001_2345, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_byte);
        add_req(32'h1023_4568, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(rand_addr(32'h0040_0000, 32'h2000), mmu_tlb_pkg::lookup_load,
                mmu_tlb_pkg::size_word);
        add_req(rand_addr(32'h1000_0000, 32'h40_0000), mmu_tlb_pkg::lookup_load,
                mmu_tlb_pkg::size_word);
        add_req(32'h0050_0010, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'h007);
        add_req(32'h0050_0010, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h0050_1010, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_half);
        add_req(32'h1020_0000, mmu_tlb_pkg::lookup_store, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
    endtask

    task automatic tlb_fault_test;
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'h005);
        write_tlb(3, make_entry(32'h0060_0000, mmu_tlb_pkg::ps_4k, 1'b1, 10'h000,
            make_page(20'h00777, 1'b0, 1'b0, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_cc),
            make_page(20'h00888, 1'b1, 1'b0, mmu_arch_pkg::plv_kernel, mmu_arch_pkg::mat_cc)));
        add_req(32'h0060_0010, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h0060_0010, mmu_tlb_pkg::lookup_store, mmu_tlb_pkg::size_word);
        add_req(32'h0060_0010, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        add_req(32'h0060_1010, mmu_tlb_pkg::lookup_store, mmu_tlb_pkg::size_word);
        add_req(32'h0060_1020, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
        set_mode(mmu_arch_pkg::plv_user, 1'b0, 10'h005);
        add_req(32'h0060_1010, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h8000_0000, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        add_req(32'h9000_0000, mmu_tlb_pkg::lookup_fetch, mmu_tlb_pkg::size_word);
        add_req(32'h0040_0100, mmu_tlb_pkg::lookup_load, mmu_tlb_pkg::size_word);
        run_requests(1'b0);
    endtask

    task automatic pipeline_test;
        set_mode(mmu_arch_pkg::plv_kernel, 1'b0, 10'h005);
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 24; i++) begin
                req_list.push_back(random_req());
            end
            run_requests(pass == 1); // Second pass stalls the response side.
        end
    endtask

    initial begin
        void'($urandom(18661));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        csr        = '0;
        tlb_we     = 1'b0;
        tlb_index  = '0;
        tlb_wentry = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            tlb_model[i] = '0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        #1;
        compare_value("resp_valid after reset", resp_valid, 0);
        compare_value("req_ready after reset", req_ready, 1);
        direct_mode_test();
        window_test();
        tlb_hit_test();
        tlb_fault_test();
        pipeline_test();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/mmu_arch_pkg.sv
logic/mmu_tlb_pkg.sv
logic/pipe_stage.sv
logic/tlb_array.sv
logic/tlb_lookup.sv
logic/addr_trans.sv
logic/mmu_top.sv
verif/mmu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
